// ==== logic/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  func3_t;
    typedef logic [6:0]  func7_t;

    // major opcodes.
    localparam opcode_t OP_ALU    = 7'b0110011;
    localparam opcode_t OP_ALUI   = 7'b0010011;
    localparam opcode_t OP_MEML   = 7'b0000011;
    localparam opcode_t OP_MEMS   = 7'b0100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_SYSTEM = 7'b1110011;
    localparam opcode_t OP_FENCE  = 7'b0001111;

    // alu funct3.
    localparam func3_t F3_ADD  = 3'b000;
    localparam func3_t F3_SLL  = 3'b001;
    localparam func3_t F3_SLT  = 3'b010;
    localparam func3_t F3_SLTU = 3'b011;
    localparam func3_t F3_XOR  = 3'b100;
    localparam func3_t F3_SR   = 3'b101;
    localparam func3_t F3_OR   = 3'b110;
    localparam func3_t F3_AND  = 3'b111;

    // branch conditions.
    localparam func3_t F3_BEQ  = 3'b000;
    localparam func3_t F3_BNE  = 3'b001;
    localparam func3_t F3_BLT  = 3'b100;
    localparam func3_t F3_BGE  = 3'b101;
    localparam func3_t F3_BLTU = 3'b110;
    localparam func3_t F3_BGEU = 3'b111;

    // load and store sizes.
    localparam func3_t F3_B  = 3'b000;
    localparam func3_t F3_H  = 3'b001;
    localparam func3_t F3_W  = 3'b010;
    localparam func3_t F3_BU = 3'b100;
    localparam func3_t F3_HU = 3'b101;

    localparam word_t RESET_PC = 32'h0000_0000;

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_WB,
        S_HALT
    } ctrl_state_t;

endpackage

// ==== logic/core_if.sv ====
`timescale 1ns/1ns

interface dec_if;
    import rv_pkg::*;

    logic      alu;
    logic      mem;
    logic      jump;
    logic      branch;
    logic      subst;
    word_t     d_rs1;   // address, base or jump target.
    word_t     d_rs2;
    word_t     d_rs3;   // immediate or branch target.
    reg_addr_t a_rd;
    opcode_t   opecode;
    func3_t    func3;
    func7_t    func7;

    modport src (output alu, mem, jump, branch, subst, d_rs1, d_rs2, d_rs3, a_rd,
                        opecode, func3, func7);
    modport sink (input alu, mem, jump, branch, subst, d_rs1, d_rs2, d_rs3, a_rd,
                        opecode, func3, func7);
endinterface

interface mem_if;
    import rv_pkg::*;

    logic   req;
    logic   write;
    word_t  addr;
    word_t  wdata;
    func3_t size;
    logic   done;   // one cycle pulse.
    word_t  rdata;  // aligned and extended.

    modport master (output req, write, addr, wdata, size, input done, rdata);
    modport slave (input req, write, addr, wdata, size, output done, rdata);
endinterface

// ==== logic/decode.sv ====
`timescale 1ns/1ns

module decode (
    input  rv_pkg::inst_t     inst,
    input  rv_pkg::word_t     pc,
    output rv_pkg::reg_addr_t regi_a_rs1,
    output rv_pkg::reg_addr_t regi_a_rs2,
    input  rv_pkg::word_t     regi_d_rs1,
    input  rv_pkg::word_t     regi_d_rs2,
    dec_if.src                dec
);
    import rv_pkg::*;

    opcode_t opc;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_j;
    word_t   imm_u;
    word_t   jal_target;
    word_t   jalr_sum;

    assign opc         = inst[6:0];
    assign dec.opecode = opc;
    assign dec.a_rd    = inst[11:7];
    assign dec.func3   = inst[14:12];
    assign dec.func7   = inst[31:25];
    assign regi_a_rs1  = inst[19:15];
    assign regi_a_rs2  = inst[24:20];

    assign dec.alu    = (opc == OP_ALU) | (opc == OP_ALUI);
    assign dec.mem    = (opc == OP_MEML) | (opc == OP_MEMS);
    assign dec.jump   = (opc == OP_JAL) | (opc == OP_JALR);
    assign dec.branch = (opc == OP_BRANCH);
    assign dec.subst  = (opc == OP_LUI) | (opc == OP_AUIPC);

    // sign-extended immediates.
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};

    assign jal_target = pc + imm_j;
    assign jalr_sum   = regi_d_rs1 + imm_i;

    always_comb begin
        case (opc)
            OP_MEML:  dec.d_rs1 = regi_d_rs1 + imm_i;
            OP_MEMS:  dec.d_rs1 = regi_d_rs1 + imm_s;
            OP_JALR:  dec.d_rs1 = {jalr_sum[31:1], 1'b0};   // lsb cleared.
            OP_JAL:   dec.d_rs1 = jal_target;
            default:  dec.d_rs1 = regi_d_rs1;
        endcase
    end

    assign dec.d_rs2 = (opc == OP_ALUI) ? imm_i : regi_d_rs2;

    always_comb begin
        case (opc)
            OP_MEMS:   dec.d_rs3 = imm_s;
            OP_BRANCH: dec.d_rs3 = pc + imm_b;
            OP_JAL:    dec.d_rs3 = jal_target;
            OP_LUI:    dec.d_rs3 = imm_u;
            OP_AUIPC:  dec.d_rs3 = pc + imm_u;
            default:   dec.d_rs3 = imm_i;
        endcase
    end

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ns

module regfile (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::reg_addr_t ra1,
    input  rv_pkg::reg_addr_t ra2,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2,
    input  logic              we,
    input  rv_pkg::reg_addr_t wa,
    input  rv_pkg::word_t     wd
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin   // x0 stays zero.
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ns

module alu (
    dec_if.sink           dec,
    output rv_pkg::word_t result,
    output logic          take
);
    import rv_pkg::*;

    logic       sub_sel;
    logic       sra_sel;
    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;
    logic       cond;

    // sub only exists for register-register ops.
    assign sub_sel = (dec.opecode == OP_ALU) & dec.func7[5];
    assign sra_sel = dec.func7[5];
    assign shamt   = dec.d_rs2[4:0];

    assign eq   = (dec.d_rs1 == dec.d_rs2);
    assign lt_s = ($signed(dec.d_rs1) < $signed(dec.d_rs2));
    assign lt_u = (dec.d_rs1 < dec.d_rs2);

    always_comb begin
        case (dec.func3)
            F3_ADD:  result = sub_sel ? dec.d_rs1 - dec.d_rs2 : dec.d_rs1 + dec.d_rs2;
            F3_SLL:  result = dec.d_rs1 << shamt;
            F3_SLT:  result = {31'b0, lt_s};
            F3_SLTU: result = {31'b0, lt_u};
            F3_XOR:  result = dec.d_rs1 ^ dec.d_rs2;
            F3_SR:   result = sra_sel ? word_t'($signed(dec.d_rs1) >>> shamt)
                                      : dec.d_rs1 >> shamt;
            F3_OR:   result = dec.d_rs1 | dec.d_rs2;
            F3_AND:  result = dec.d_rs1 & dec.d_rs2;
            default: result = '0;
        endcase
    end

    always_comb begin
        case (dec.func3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = ~eq;
            F3_BLT:  cond = lt_s;
            F3_BGE:  cond = ~lt_s;
            F3_BLTU: cond = lt_u;
            F3_BGEU: cond = ~lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign take = dec.branch & cond;

endmodule

// ==== logic/bus_master.sv ====
`timescale 1ns/1ns

module bus_master (
    input  logic          clk,
    input  logic          arst_n,
    mem_if.slave          mreq,
    output rv_pkg::word_t awaddr,
    output logic          awvalid,
    input  logic          awready,
    output rv_pkg::word_t wdata,
    output logic [3:0]    wstrb,
    output logic          wvalid,
    input  logic          wready,
    input  logic          bvalid,
    output logic          bready,
    output rv_pkg::word_t araddr,
    output logic          arvalid,
    input  logic          arready,
    input  rv_pkg::word_t rdata,
    input  logic          rvalid,
    output logic          rready
);
    import rv_pkg::*;

    typedef enum logic [2:0] {
        B_IDLE,
        B_AW_W,
        B_RESP,
        B_ADDR,
        B_DATA
    } bus_state_t;

    bus_state_t  state;
    logic [1:0]  off;
    word_t       st_data;
    logic [3:0]  st_strb;
    word_t       byte_sh;
    word_t       half_sh;

    // AWPROT and ARPROT are left at zero by the top level.
    assign off = mreq.addr[1:0];

    always_comb begin
        case (mreq.size)
            F3_B: begin
                st_data = {4{mreq.wdata[7:0]}};
                st_strb = 4'b0001 << off;
            end
            F3_H: begin
                st_data = {2{mreq.wdata[15:0]}};
                st_strb = 4'b0011 << {off[1], 1'b0};
            end
            default: begin
                st_data = mreq.wdata;
                st_strb = 4'b1111;
            end
        endcase
    end

    assign byte_sh = rdata >> {off, 3'b000};
    assign half_sh = rdata >> {off[1], 4'b0000};

    always_comb begin
        case (mreq.size)
            F3_B:    mreq.rdata = {{24{byte_sh[7]}}, byte_sh[7:0]};
            F3_BU:   mreq.rdata = {24'h000000, byte_sh[7:0]};
            F3_H:    mreq.rdata = {{16{half_sh[15]}}, half_sh[15:0]};
            F3_HU:   mreq.rdata = {16'h0000, half_sh[15:0]};
            default: mreq.rdata = rdata;
        endcase
    end

    assign bready    = (state == B_RESP);
    assign rready    = (state == B_DATA);
    assign mreq.done = (bready & bvalid) | (rready & rvalid);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= B_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            case (state)
                B_IDLE: if (mreq.req) begin
                    if (mreq.write) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= B_AW_W;
                    end else begin
                        arvalid <= 1'b1;
                        state   <= B_ADDR;
                    end
                end
                B_AW_W: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    // both channels done, counting this cycle.
                    if ((!awvalid || awready) && (!wvalid || wready)) state <= B_RESP;
                end
                B_RESP: if (bvalid) state <= B_IDLE;
                B_ADDR: if (arready) begin
                    arvalid <= 1'b0;
                    state   <= B_DATA;
                end
                B_DATA: if (rvalid) state <= B_IDLE;
                default: state <= B_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == B_IDLE) && mreq.req) begin
            awaddr <= {mreq.addr[31:2], 2'b00};
            araddr <= {mreq.addr[31:2], 2'b00};
            wdata  <= st_data;
            wstrb  <= st_strb;
        end
    end

endmodule

// ==== logic/core_ctrl.sv ====
`timescale 1ns/1ns

module core_ctrl (
    input  logic              clk,
    input  logic              arst_n,
    dec_if.sink               dec,
    input  rv_pkg::word_t     alu_result,
    input  logic              take,
    output rv_pkg::inst_t     inst,
    output rv_pkg::word_t     pc,
    output logic              rf_we,
    output rv_pkg::reg_addr_t rf_wa,
    output rv_pkg::word_t     rf_wd,
    mem_if.master             mreq,
    output logic              halted
);
    import rv_pkg::*;

    ctrl_state_t state;
    word_t       pc_q;
    inst_t       ir;
    word_t       load_q;
    word_t       pc_inc;
    word_t       pc_next;
    logic        is_load;
    logic        wb_en;

    assign inst    = ir;
    assign pc      = pc_q;
    assign pc_inc  = pc_q + 32'd4;
    assign is_load = (dec.opecode == OP_MEML);
    assign wb_en   = dec.alu | is_load | dec.jump | dec.subst;

    always_comb begin
        if (dec.jump) begin
            pc_next = dec.d_rs1;
        end else if (take) begin
            pc_next = dec.d_rs3;
        end else begin
            pc_next = pc_inc;
        end
    end

    // write-back.
    assign rf_we = (state == S_WB) & wb_en;
    assign rf_wa = dec.a_rd;

    always_comb begin
        if (dec.jump) begin
            rf_wd = pc_inc;   // link value.
        end else if (dec.subst) begin
            rf_wd = dec.d_rs3;
        end else if (is_load) begin
            rf_wd = load_q;
        end else begin
            rf_wd = alu_result;
        end
    end

    // fetch uses the request port as a word read.
    always_comb begin
        mreq.req   = (state == S_FETCH) | (state == S_MEM);
        mreq.write = (state == S_MEM) & (dec.opecode == OP_MEMS);
        mreq.addr  = (state == S_MEM) ? dec.d_rs1 : pc_q;
        mreq.wdata = dec.d_rs2;
        mreq.size  = (state == S_MEM) ? dec.func3 : F3_W;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= S_FETCH;
            pc_q   <= RESET_PC;
            halted <= 1'b0;
        end else begin
            halted <= (state == S_HALT);
            case (state)
                S_FETCH: if (mreq.done) state <= S_EXEC;
                S_EXEC: begin
                    case (dec.opecode)
                        OP_SYSTEM: state <= S_HALT;
                        OP_FENCE:  state <= S_WB;   // no-op, pc just advances.
                        default:   state <= dec.mem ? S_MEM : S_WB;
                    endcase
                end
                S_MEM: if (mreq.done) state <= S_WB;
                S_WB: begin
                    pc_q  <= pc_next;
                    state <= S_FETCH;
                end
                S_HALT: state <= S_HALT;
                default: state <= S_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_FETCH) && mreq.done) begin
            ir <= mreq.rdata;
        end
        if ((state == S_MEM) && mreq.done) begin
            load_q <= mreq.rdata;
        end
    end

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
    input  logic          clk,
    input  logic          arst_n,
    output rv_pkg::word_t awaddr,
    output logic          awvalid,
    input  logic          awready,
    output rv_pkg::word_t wdata,
    output logic [3:0]    wstrb,
    output logic          wvalid,
    input  logic          wready,
    input  logic          bvalid,
    output logic          bready,
    output rv_pkg::word_t araddr,
    output logic          arvalid,
    input  logic          arready,
    input  rv_pkg::word_t rdata,
    input  logic          rvalid,
    output logic          rready,
    output logic          halted
);
    import rv_pkg::*;

    inst_t     inst;
    word_t     pc;
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;
    logic      rf_we;
    reg_addr_t rf_wa;
    word_t     rf_wd;
    word_t     alu_result;
    logic      take;

    dec_if dec_bus ();
    mem_if mem_bus ();

    decode u_decode (
        .inst(inst), .pc(pc), .regi_a_rs1(ra1), .regi_a_rs2(ra2),
        .regi_d_rs1(rd1), .regi_d_rs2(rd2), .dec(dec_bus)
    );

    regfile u_regfile (
        .clk(clk), .arst_n(arst_n), .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
        .we(rf_we), .wa(rf_wa), .wd(rf_wd)
    );

    alu u_alu (.dec(dec_bus), .result(alu_result), .take(take));

    core_ctrl u_core_ctrl (
        .clk(clk), .arst_n(arst_n), .dec(dec_bus), .alu_result(alu_result), .take(take),
        .inst(inst), .pc(pc), .rf_we(rf_we), .rf_wa(rf_wa), .rf_wd(rf_wd),
        .mreq(mem_bus), .halted(halted)
    );

    bus_master u_bus_master (
        .clk(clk), .arst_n(arst_n), .mreq(mem_bus),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready)
    );

endmodule

// ==== verif/axil_mem_model.sv ====
`timescale 1ns/1ns

module axil_mem_model (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [1:0]  max_delay,   // 0 means always ready.
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    input  logic        rready
);
    logic [31:0] mem [0:1023];   // backdoor word array.
    logic        aw_got;
    logic        w_got;
    logic        r_pend;
    logic [31:0] aw_a;
    logic [31:0] w_d;
    logic [3:0]  w_s;
    logic [31:0] ar_a;
    logic        b_hs;
    logic        r_hs;
    int          aw_cnt;
    int          w_cnt;
    int          b_cnt;
    int          ar_cnt;
    int          r_cnt;

    function automatic int pick_delay();
        if (max_delay == 2'd0) return 0;
        return int'($urandom % ({30'b0, max_delay} + 32'd1));
    endfunction

    always begin
        @(posedge clk or negedge arst_n);
        if (!arst_n) begin
            awready = 1'b0;
            wready  = 1'b0;
            bvalid  = 1'b0;
            arready = 1'b0;
            rvalid  = 1'b0;
            rdata   = '0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
            r_pend  = 1'b0;
            aw_cnt  = 0;
            w_cnt   = 0;
            b_cnt   = 0;
            ar_cnt  = 0;
            r_cnt   = 0;
        end else begin
            // handshakes as seen at the edge.
            if (awvalid && awready) begin
                aw_a   = awaddr;
                aw_got = 1'b1;
                aw_cnt = pick_delay();
            end
            if (wvalid && wready) begin
                w_d    = wdata;
                w_s    = wstrb;
                w_got  = 1'b1;
                w_cnt  = pick_delay();
            end
            if (arvalid && arready) begin
                ar_a   = araddr;
                r_pend = 1'b1;
                r_cnt  = pick_delay();
                ar_cnt = pick_delay();
            end
            b_hs = bvalid && bready;
            r_hs = rvalid && rready;
            #1;
            awready = 1'b0;
            wready  = 1'b0;
            arready = 1'b0;
            if (b_hs) bvalid = 1'b0;
            if (r_hs) rvalid = 1'b0;
            if (awvalid && !aw_got) begin
                if (aw_cnt == 0) awready = 1'b1;
                else aw_cnt--;
            end
            if (wvalid && !w_got) begin
                if (w_cnt == 0) wready = 1'b1;
                else w_cnt--;
            end
            if (aw_got && w_got && !bvalid) begin
                if (b_cnt == 0) begin
                    for (int b = 0; b < 4; b++) begin
                        if (w_s[b]) mem[aw_a[11:2]][8*b +: 8] = w_d[8*b +: 8];
                    end
                    bvalid = 1'b1;
                    aw_got = 1'b0;
                    w_got  = 1'b0;
                    b_cnt  = pick_delay();
                end else begin
                    b_cnt--;
                end
            end
            if (arvalid && !r_pend && !rvalid) begin
                if (ar_cnt == 0) arready = 1'b1;
                else ar_cnt--;
            end
            if (r_pend) begin
                if (r_cnt == 0) begin
                    rdata  = mem[ar_a[11:2]];
                    rvalid = 1'b1;
                    r_pend = 1'b0;
                end else begin
                    r_cnt--;
                end
            end
        end
    end

endmodule

// ==== verif/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;
    localparam logic [6:0] OPC_ALUI  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [31:0] ECALL    = 32'h0000_0073;
    localparam logic [31:0] VAL_A    = 32'h8765_4321;
    localparam logic [31:0] VAL_B    = 32'h0000_0005;

    logic        clk;
    logic        arst_n;
    logic [1:0]  max_delay;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;
    logic        halted;

    logic [31:0] prog [$];
    logic [31:0] expq [$];
    logic [3:0]  strb_log [$];
    logic [31:0] snap [0:1023];

    cpu_top dut (.*);
    axil_mem_model mem_model (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (wvalid && wready) strb_log.push_back(wstrb);
    end

    function automatic logic [31:0] fill_word(input int i);
        return 32'h1357_9bdf ^ (32'(i) * 32'h0101_0101);
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {f7, rs2, rs1, f3, 5'd4, 7'b0110011};   // rd is always x4.
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd3, f3, imm[4:0], 7'b0100011};   // base x3.
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] pc_now();
        return 32'(prog.size() * 4);
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic load_imm(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] hi;
        hi = val + 32'h800;
        emit({hi[31:12], rd, OPC_LUI});
        emit(i_type(val[11:0], rd, 3'b000, rd, OPC_ALUI));
    endtask

    // store rs into the next result slot and remember its expected value.
    task automatic store_expect(input logic [4:0] rs, input logic [31:0] exp);
        emit(s_type(12'(4 * expq.size()), rs, 3'b010));
        expq.push_back(exp);
    endtask

    task automatic alu_case(input logic [31:0] inst, input logic [31:0] exp);
        emit(inst);
        store_expect(5'd4, exp);
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    task automatic hold_reset();
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        strb_log.delete();
        for (int i = 0; i < 1024; i++) mem_model.mem[i] = fill_word(i);
        foreach (prog[i]) mem_model.mem[i] = prog[i];
    endtask

    task automatic release_and_run();
        int n;
        repeat (8) begin
            @(posedge clk);
            #1;
            check_word("awvalid", {31'b0, awvalid}, 32'h0);
            check_word("wvalid", {31'b0, wvalid}, 32'h0);
            check_word("arvalid", {31'b0, arvalid}, 32'h0);
        end
        arst_n = 1'b1;
        n = 0;
        while (!arvalid && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!arvalid) fail_run("the first instruction fetch never started");
        assert (n == 1)
        else fail_run("the first fetch did not start in the first cycle after reset");
        check_word("awvalid", {31'b0, awvalid}, 32'h0);
        check_word("wvalid", {31'b0, wvalid}, 32'h0);
        check_word("araddr", araddr, 32'h0);
        n = 0;
        while (!halted && n < 5000) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!halted) fail_run("halted never came within 5000 cycles");
    endtask

    task automatic check_results(input int base);
        foreach (expq[k]) check_word($sformatf("mem[%0d]", base + k),
                                     mem_model.mem[base + k], expq[k]);
    endtask

    task automatic build_alu_prog();
        prog.delete();
        expq.delete();
        load_imm(1, VAL_A);
        load_imm(2, VAL_B);
        load_imm(3, 32'h800);
        alu_case(r_type(7'h00, 2, 1, 3'b000), VAL_A + VAL_B);
        alu_case(r_type(7'h20, 2, 1, 3'b000), VAL_A - VAL_B);
        alu_case(r_type(7'h00, 2, 1, 3'b001), VAL_A << 5);
        alu_case(r_type(7'h00, 2, 1, 3'b010), 32'd1);   // A is negative.
        alu_case(r_type(7'h00, 2, 1, 3'b011), 32'd0);
        alu_case(r_type(7'h00, 2, 1, 3'b100), VAL_A ^ VAL_B);
        alu_case(r_type(7'h00, 2, 1, 3'b101), VAL_A >> 5);
        alu_case(r_type(7'h20, 2, 1, 3'b101), 32'($signed(VAL_A) >>> 5));
        alu_case(r_type(7'h00, 2, 1, 3'b110), VAL_A | VAL_B);
        alu_case(r_type(7'h00, 2, 1, 3'b111), VAL_A & VAL_B);
        alu_case(i_type(12'hf9c, 1, 3'b000, 4, OPC_ALUI), VAL_A - 32'd100);
        alu_case(i_type(12'h0f0, 1, 3'b100, 4, OPC_ALUI), VAL_A ^ 32'h0f0);
        alu_case(i_type(12'h7ff, 1, 3'b110, 4, OPC_ALUI), VAL_A | 32'h7ff);
        alu_case(i_type(12'hf00, 1, 3'b111, 4, OPC_ALUI), VAL_A & 32'hffff_ff00);
        alu_case(i_type(12'h007, 1, 3'b001, 4, OPC_ALUI), VAL_A << 7);
        alu_case(i_type(12'h009, 1, 3'b101, 4, OPC_ALUI), VAL_A >> 9);
        alu_case(i_type(12'h409, 1, 3'b101, 4, OPC_ALUI), 32'($signed(VAL_A) >>> 9));
        alu_case(i_type(12'h001, 1, 3'b010, 4, OPC_ALUI), 32'd1);
        alu_case(i_type(12'h003, 2, 3'b011, 4, OPC_ALUI), 32'd0);
        emit(ECALL);
    endtask

    task automatic test_alu();
        build_alu_prog();
        hold_reset();
        release_and_run();
        check_results(512);
        for (int i = 0; i < 1024; i++) snap[i] = mem_model.mem[i];
    endtask

    task automatic test_load_store();
        logic [31:0] d;
        logic [31:0] w;
        logic [7:0]  by;
        logic [15:0] hw;
        logic [3:0]  strb_exp [6];
        d = 32'h80f1_7f02;
        strb_exp = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc};
        prog.delete();
        expq.delete();
        load_imm(3, 32'h900);
        load_imm(5, 32'ha5b6_c7d8);
        for (int k = 0; k < 4; k++) emit(s_type(12'(5 * k), 5, 3'b000));
        for (int k = 0; k < 2; k++) emit(s_type(12'(16 + 6 * k), 5, 3'b001));
        // loads come from 0x920, results go to 0x940.
        for (int k = 0; k < 12; k++) begin
            if (k < 4) emit(i_type(12'(32 + k), 3, 3'b000, 6, OPC_LOAD));
            else if (k < 8) emit(i_type(12'(28 + k), 3, 3'b100, 6, OPC_LOAD));
            else if (k < 10) emit(i_type(12'(32 + 2 * (k - 8)), 3, 3'b001, 6, OPC_LOAD));
            else emit(i_type(12'(32 + 2 * (k - 10)), 3, 3'b101, 6, OPC_LOAD));
            emit(s_type(12'(64 + 4 * k), 6, 3'b010));
        end
        emit(ECALL);
        hold_reset();
        mem_model.mem[584] = d;
        release_and_run();
        for (int k = 0; k < 6; k++) begin
            check_word($sformatf("wstrb[%0d]", k), {28'b0, strb_log[k]}, {28'b0, strb_exp[k]});
        end
        for (int k = 0; k < 4; k++) begin
            w = fill_word(576 + k);
            w[8*k +: 8] = 8'hd8;
            check_word($sformatf("mem[%0d]", 576 + k), mem_model.mem[576 + k], w);
        end
        for (int k = 0; k < 2; k++) begin
            w = fill_word(580 + k);
            w[16*k +: 16] = 16'hc7d8;
            check_word($sformatf("mem[%0d]", 580 + k), mem_model.mem[580 + k], w);
        end
        for (int k = 0; k < 4; k++) begin
            by = d[8*k +: 8];
            check_word("lb", mem_model.mem[592 + k], 32'($signed(by)));
            check_word("lbu", mem_model.mem[596 + k], {24'h0, by});
        end
        for (int k = 0; k < 2; k++) begin
            hw = d[16*k +: 16];
            check_word("lh", mem_model.mem[600 + k], 32'($signed(hw)));
            check_word("lhu", mem_model.mem[602 + k], {16'h0, hw});
        end
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic taken);
        emit(i_type(12'd0, 0, 3'b000, 11, OPC_ALUI));
        emit(b_type(13'd12, rs1, rs2, f3));
        emit(i_type(12'd1, 0, 3'b000, 11, OPC_ALUI));    // skipped when taken.
        emit(i_type(12'd1, 10, 3'b000, 10, OPC_ALUI));
        store_expect(5'd11, taken ? 32'd0 : 32'd1);
    endtask

    task automatic test_control_flow();
        logic [31:0] at;
        prog.delete();
        expq.delete();
        load_imm(3, 32'ha00);
        load_imm(1, 32'd5);
        load_imm(2, 32'hffff_fffd);
        branch_case(3'b000, 1, 1, 1'b1);
        branch_case(3'b000, 1, 2, 1'b0);
        branch_case(3'b001, 1, 2, 1'b1);
        branch_case(3'b001, 1, 1, 1'b0);
        branch_case(3'b100, 2, 1, 1'b1);
        branch_case(3'b100, 1, 2, 1'b0);
        branch_case(3'b101, 1, 2, 1'b1);
        branch_case(3'b101, 2, 1, 1'b0);
        branch_case(3'b110, 1, 2, 1'b1);
        branch_case(3'b110, 2, 1, 1'b0);
        branch_case(3'b111, 2, 1, 1'b1);
        branch_case(3'b111, 1, 2, 1'b0);
        store_expect(5'd10, 32'd6);   // not-taken count.
        at = pc_now();
        emit(j_type(21'd8, 12));
        emit(i_type(12'd1, 0, 3'b000, 13, OPC_ALUI));
        store_expect(5'd12, at + 32'd4);
        load_imm(14, pc_now() + 32'd16);
        at = pc_now();
        emit(i_type(12'd1, 14, 3'b000, 15, OPC_JALR));   // odd sum, lsb dropped.
        emit(i_type(12'd1, 0, 3'b000, 13, OPC_ALUI));
        store_expect(5'd15, at + 32'd4);
        store_expect(5'd13, 32'd0);
        emit({20'habcde, 5'd16, OPC_LUI});
        store_expect(5'd16, 32'habcd_e000);
        at = pc_now();
        emit({20'h12345, 5'd17, OPC_AUIPC});
        store_expect(5'd17, at + 32'h1234_5000);
        emit(ECALL);
        hold_reset();
        release_and_run();
        check_results(640);
    endtask

    task automatic test_backpressure();
        build_alu_prog();
        hold_reset();
        max_delay = 2'd3;
        release_and_run();
        max_delay = 2'd0;
        for (int i = 0; i < 1024; i++) begin
            check_word($sformatf("mem[%0d]", i), mem_model.mem[i], snap[i]);
        end
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        max_delay = 2'd0;
        void'($urandom(8));
        test_alu();
        test_load_store();
        test_control_flow();
        test_backpressure();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
logic/rv_pkg.sv
logic/core_if.sv
logic/decode.sv
logic/regfile.sv
logic/alu.sv
logic/bus_master.sv
logic/core_ctrl.sv
logic/cpu_top.sv
verif/axil_mem_model.sv
verif/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_cpu -f all.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
grep -q "ALL TESTS PASSED" sim.log
